//--- logic/mduPkg.sv
/*
 * MDU package: M-extension operation codes, register index type,
 * the pipeline tag struct and the stall/flush control struct
 */
package mduPkg;

  // funct3 encodings of the M extension
  typedef enum logic [2:0] {
    opMul    = 3'b000,
    opMulh   = 3'b001,
    opMulhsu = 3'b010,
    opMulhu  = 3'b011,
    opDiv    = 3'b100,
    opDivu   = 3'b101,
    opRem    = 3'b110,
    opRemu   = 3'b111
  } mduOpE;

  typedef logic [4:0] regIdxT;

  // travels with the data through E, M and W
  typedef struct packed {
    logic   valid;
    mduOpE  op;
    regIdxT rd;
  } mduTagT;

  typedef struct packed {
    logic stallE;
    logic stallM;
    logic stallW;
    logic flushM;
    logic flushW;
  } stallCtlT;

  // divide and remainder ops all have funct3[2] set
  function automatic logic isDivOp(input mduOpE op);
    return op[2];
  endfunction

endpackage

//--- logic/hazardCtl.sv
/*
 * Hazard control: per-stage stall and flush from the divider busy
 * flag and the external stall
 */
`timescale 1ns/1ps

module hazardCtl import mduPkg::*; (
  input  logic     divBusy,
  input  logic     externalStall,
  output stallCtlT stallCtl
);

  logic stallE;
  logic stallM;
  logic stallW;

  //////////////////////////////////////////////////
  // stall chain
  //////////////////////////////////////////////////

  assign stallE = divBusy || externalStall;  // divider holds execute only
  assign stallM = externalStall;
  assign stallW = externalStall;

  // a held stage feeds a bubble into a moving one
  always_comb begin
    stallCtl.stallE = stallE;
    stallCtl.stallM = stallM;
    stallCtl.stallW = stallW;
    stallCtl.flushM = stallE && !stallM;
    stallCtl.flushW = stallM && !stallW;
  end

endmodule

//--- logic/mulPipe.sv
/*
 * Two-stage multiplier: operand extension and full product in execute,
 * product register in memory, high/low half select into writeback
 */
`timescale 1ns/1ps

module mulPipe import mduPkg::*; #(
  parameter int xlen = 32
) (
  input  logic            clk,
  input  logic            rstN,
  input  stallCtlT        stallCtl,
  input  logic            flushE,
  input  mduTagT          issueTag,
  input  logic [xlen-1:0] srcA,
  input  logic [xlen-1:0] srcB,
  output logic [xlen-1:0] mulResult
);

  localparam int prodW = 2 * xlen;

  logic             signA;
  logic             signB;
  logic [prodW-1:0] extA;
  logic [prodW-1:0] extB;
  logic [prodW-1:0] productE;
  logic [prodW-1:0] productM;
  logic             loadM;
  logic             selHighM;

  //////////////////////////////////////////////////
  // execute stage
  //////////////////////////////////////////////////

  always_comb begin
    signA = (issueTag.op == opMulh) || (issueTag.op == opMulhsu);
    signB = (issueTag.op == opMulh);  // MULHSU keeps rs2 unsigned
    extA  = {{xlen{signA & srcA[xlen-1]}}, srcA};
    extB  = {{xlen{signB & srcB[xlen-1]}}, srcB};
    productE = extA * extB;  // low 2*xlen bits are exact for both signs
  end

  // only live multiplies that actually leave execute are captured
  assign loadM = issueTag.valid && !isDivOp(issueTag.op) && !flushE && !stallCtl.stallE;

  //////////////////////////////////////////////////
  // memory stage
  //////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!rstN) begin
      selHighM <= 1'b0;
    end else if (loadM) begin
      selHighM <= (issueTag.op != opMul);
    end
  end

  always_ff @(posedge clk) begin
    if (loadM) begin
      productM <= productE;
    end
  end

  // sampled by the writeback register
  assign mulResult = selHighM ? productM[prodW-1:xlen] : productM[xlen-1:0];

endmodule

//--- logic/divFsm.sv
/*
 * Divider control FSM: idle, busy and done states, start and abort
 * strobes, and the busy flag that stalls execute
 */
`timescale 1ns/1ps

module divFsm import mduPkg::*; (
  input  logic   clk,
  input  logic   rstN,
  input  mduTagT issueTag,
  input  logic   flushE,
  input  logic   lastStep,
  output logic   start,
  output logic   abort,
  output logic   divBusy
);

  typedef enum logic [1:0] {
    idleS,
    busyS,
    doneS
  } divStateE;

  divStateE state;
  divStateE stateNext;
  logic     divInE;

  assign divInE = issueTag.valid && isDivOp(issueTag.op) && !flushE;

  assign start = (state == idleS) && divInE;
  assign abort = flushE && (state != idleS);  // kill a divide in flight

  // high from the first execute cycle, low in done so the op moves on
  assign divBusy = start || ((state == busyS) && !flushE);

  always_comb begin
    stateNext = state;
    case (state)
      idleS:   if (start) stateNext = busyS;
      busyS:   if (lastStep) stateNext = doneS;
      doneS:   stateNext = idleS;
      default: stateNext = idleS;
    endcase
    if (flushE) begin
      stateNext = idleS;
    end
  end

  always_ff @(posedge clk) begin
    if (!rstN) begin
      state <= idleS;
    end else begin
      state <= stateNext;
    end
  end

  //////////////////////////////////////////////////
  // checks
  //////////////////////////////////////////////////

  // the divide being worked on stays in execute until it finishes
  assert property (@(posedge clk) disable iff (!rstN)
                   ((state == busyS) && !flushE) |-> (issueTag.valid && isDivOp(issueTag.op)))
    else $error("divide left execute while the divider was busy");

  // counter and FSM must agree on the final iteration
  assert property (@(posedge clk) disable iff (!rstN) lastStep |-> (state == busyS))
    else $error("lastStep outside the busy state");

endmodule

//--- logic/divCounter.sv
/*
 * Divide iteration counter, flags the final shift-subtract step
 */
`timescale 1ns/1ps

module divCounter #(
  parameter int xlen = 32
) (
  input  logic clk,
  input  logic rstN,
  input  logic start,
  input  logic abort,
  output logic lastStep
);

  localparam int cntW = (xlen > 1) ? $clog2(xlen) : 1;

  logic [cntW-1:0] count;
  logic            running;

  assign lastStep = running && (count == cntW'(xlen - 1));

  always_ff @(posedge clk) begin
    if (!rstN || abort) begin
      running <= 1'b0;
      count   <= '0;
    end else if (start) begin
      running <= 1'b1;
      count   <= '0;
    end else if (running) begin
      if (lastStep) begin
        running <= 1'b0;  // wait for the next start
        count   <= '0;
      end else begin
        count <= count + 1'b1;
      end
    end
  end

  // the FSM only starts once the previous run has ended
  assert property (@(posedge clk) disable iff (!rstN) start |-> !running)
    else $error("start while the counter is still running");

endmodule

//--- logic/divDatapath.sv
/*
 * Restoring shift-subtract divider on magnitudes, with sign fixup
 * and the RISC-V divide-by-zero and overflow results
 */
`timescale 1ns/1ps

module divDatapath import mduPkg::*; #(
  parameter int xlen = 32
) (
  input  logic            clk,
  input  logic            rstN,
  input  logic            start,
  input  mduTagT          issueTag,
  input  logic [xlen-1:0] srcA,
  input  logic [xlen-1:0] srcB,
  output logic [xlen-1:0] divResult
);

  localparam logic [xlen-1:0] minNeg = {1'b1, {(xlen - 1){1'b0}}};

  // result fixups, latched with the operands
  typedef struct packed {
    logic isRem;
    logic negQ;
    logic negR;
    logic divZero;
    logic overflow;
  } fixT;

  logic            signedOp;
  logic [xlen-1:0] absA;
  logic [xlen-1:0] absB;
  fixT             fixIn;
  fixT             fix;
  logic [xlen-1:0] remReg;
  logic [xlen-1:0] quoReg;  // dividend bits out the top, quotient bits in
  logic [xlen-1:0] dvsReg;
  logic [xlen:0]   shifted;
  logic [xlen:0]   diff;
  logic [xlen-1:0] quo;
  logic [xlen-1:0] rem;

  //////////////////////////////////////////////////
  // operand load
  //////////////////////////////////////////////////

  always_comb begin
    signedOp = (issueTag.op == opDiv) || (issueTag.op == opRem);
    absA = (signedOp && srcA[xlen-1]) ? -srcA : srcA;
    absB = (signedOp && srcB[xlen-1]) ? -srcB : srcB;
    fixIn.isRem    = (issueTag.op == opRem) || (issueTag.op == opRemu);
    fixIn.negQ     = signedOp && (srcA[xlen-1] ^ srcB[xlen-1]);
    fixIn.negR     = signedOp && srcA[xlen-1];  // remainder follows the dividend
    fixIn.divZero  = (srcB == '0);
    fixIn.overflow = signedOp && (srcA == minNeg) && (srcB == '1);
  end

  always_ff @(posedge clk) begin
    if (!rstN) begin
      fix <= '0;
    end else if (start) begin
      fix <= fixIn;
    end
  end

  //////////////////////////////////////////////////
  // iteration
  //////////////////////////////////////////////////

  always_comb begin
    shifted = {remReg, quoReg[xlen-1]};
    diff    = shifted - {1'b0, dvsReg};  // top bit set means borrow
  end

  always_ff @(posedge clk) begin
    if (start) begin
      remReg <= '0;
      quoReg <= absA;
      dvsReg <= absB;
    end else begin
      remReg <= diff[xlen] ? shifted[xlen-1:0] : diff[xlen-1:0];
      quoReg <= {quoReg[xlen-2:0], ~diff[xlen]};
    end
  end

  // valid once xlen steps have run, read in the done cycle
  always_comb begin
    quo = fix.negQ ? -quoReg : quoReg;
    rem = fix.negR ? -remReg : remReg;
    if (fix.divZero) begin
      quo = '1;  // remainder already equals the dividend
    end
    if (fix.overflow) begin
      quo = minNeg;
      rem = '0;
    end
    divResult = fix.isRem ? rem : quo;
  end

endmodule

//--- logic/mduWriteback.sv
/*
 * Memory and writeback tag registers, divider result capture and
 * final result select between multiplier and divider
 */
`timescale 1ns/1ps

module mduWriteback import mduPkg::*; #(
  parameter int xlen = 32
) (
  input  logic            clk,
  input  logic            rstN,
  input  stallCtlT        stallCtl,
  input  logic            flushE,
  input  mduTagT          issueTag,
  input  logic [xlen-1:0] mulResult,
  input  logic [xlen-1:0] divResult,
  output mduTagT          writeTag,
  output logic [xlen-1:0] writeData
);

  mduTagT          tagM;
  mduTagT          tagW;
  logic [xlen-1:0] divResultM;
  logic [xlen-1:0] dataW;

  //////////////////////////////////////////////////
  // memory stage
  //////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!rstN) begin
      tagM <= '0;
    end else if (!stallCtl.stallM) begin
      if (stallCtl.flushM || flushE) begin
        tagM <= '0;  // bubble
      end else begin
        tagM <= issueTag;
      end
    end
  end

  // divider result is final only in the cycle the divide leaves execute
  always_ff @(posedge clk) begin
    if (!stallCtl.stallE && issueTag.valid && isDivOp(issueTag.op)) begin
      divResultM <= divResult;
    end
  end

  //////////////////////////////////////////////////
  // writeback stage
  //////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!rstN) begin
      tagW <= '0;
    end else if (!stallCtl.stallW) begin
      if (stallCtl.flushW) begin
        tagW <= '0;
      end else begin
        tagW <= tagM;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!stallCtl.stallW) begin
      dataW <= isDivOp(tagM.op) ? divResultM : mulResult;
    end
  end

  // register write enable, held off while writeback is stalled
  always_comb begin
    writeTag       = tagW;
    writeTag.valid = tagW.valid && !stallCtl.stallW;
  end

  assign writeData = dataW;

endmodule

//--- logic/mduTop.sv
/*
 * MDU top level: hazard control, multiplier, divider FSM, counter
 * and datapath, and the writeback stage
 */
`timescale 1ns/1ps

module mduTop import mduPkg::*; #(
  parameter int xlen = 32
) (
  input  logic            clk,
  input  logic            rstN,
  input  mduTagT          issueTag,
  input  logic [xlen-1:0] srcA,
  input  logic [xlen-1:0] srcB,
  input  logic            flushE,
  input  logic            externalStall,
  output logic            stallE,
  output mduTagT          writeTag,
  output logic [xlen-1:0] writeData
);

  stallCtlT        stallCtl;
  logic            divBusy;
  logic            start;
  logic            abort;
  logic            lastStep;
  logic [xlen-1:0] mulResult;
  logic [xlen-1:0] divResult;

  assign stallE = stallCtl.stallE;

  // global stall and flush
  hazardCtl i_hazard (.divBusy, .externalStall, .stallCtl);

  mulPipe #(.xlen(xlen)) i_mul (
    .clk, .rstN, .stallCtl, .flushE, .issueTag,
    .srcA, .srcB, .mulResult
  );

  //////////////////////////////////////////////////
  // divider
  //////////////////////////////////////////////////

  divFsm i_divFsm (
    .clk, .rstN, .issueTag, .flushE, .lastStep,
    .start, .abort, .divBusy
  );

  divCounter #(.xlen(xlen)) i_divCounter (.clk, .rstN, .start, .abort, .lastStep);

  divDatapath #(.xlen(xlen)) i_divDatapath (
    .clk, .rstN, .start, .issueTag,
    .srcA, .srcB, .divResult
  );

  // results leave in issue order
  mduWriteback #(.xlen(xlen)) i_writeback (
    .clk, .rstN, .stallCtl, .flushE, .issueTag,
    .mulResult, .divResult, .writeTag, .writeData
  );

endmodule

//--- sim/clkGen.sv
/*
 * Testbench clock and synchronous active-low reset
 */
`timescale 1ns/1ps

module clkGen #(
  parameter int periodNs    = 4,
  parameter int resetCycles = 16
) (
  output logic clk,
  output logic rstN
);

  initial begin
    clk = 1'b0;
    forever #(periodNs / 2) clk = ~clk;
  end

  initial begin
    rstN = 1'b0;
    repeat (resetCycles) @(posedge clk);
    @(negedge clk);  // release away from the sampling edge
    rstN = 1'b1;
  end

endmodule

//--- sim/mduTb.sv
/*
 * MDU testbench: directed tests for multiply, divide, special cases,
 * back-to-back issue, flush and external stall, with a reference model,
 * result monitor, watchdog and summary
 */
`timescale 1ns/1ps

module mduTb import mduPkg::*; ();

  localparam int xlen        = 32;
  localparam int periodNs    = 4;
  localparam int resetCycles = 16;
  localparam int mulPerOp    = 8;  // first four use the corner pairs
  localparam int divPerOp    = 3;
  localparam int numOps      = 4 * mulPerOp + 4 * divPerOp + 6 + 5 + 3 + 6;

  // {srcA, srcB}
  localparam logic [63:0] mulCorners [4] = '{
    64'h0000_0000_ffff_ffff, 64'hffff_ffff_ffff_ffff,
    64'h8000_0000_ffff_ffff, 64'h7fff_ffff_8000_0000
  };

  typedef struct packed {
    mduTagT          tag;
    logic [xlen-1:0] data;
    logic [31:0]     presCycle;  // cycle count when first put on issueTag
    logic            checkLat;
  } expectT;

  logic            clk;
  logic            rstN;
  mduTagT          issueTag;
  logic [xlen-1:0] srcA;
  logic [xlen-1:0] srcB;
  logic            flushE;
  logic            externalStall;
  logic            stallE;
  mduTagT          writeTag;
  logic [xlen-1:0] writeData;

  expectT      expectQ[$];
  integer      seed;
  string       testName;
  int          valueErrors = 0;
  int          otherErrors = 0;
  int          lastStalls;
  logic [31:0] cycleCount = '0;

  clkGen #(.periodNs(periodNs), .resetCycles(resetCycles)) i_clkGen (.clk, .rstN);

  mduTop #(.xlen(xlen)) i_dut (
    .clk, .rstN, .issueTag, .srcA, .srcB, .flushE, .externalStall,
    .stallE, .writeTag, .writeData
  );

  always @(posedge clk) cycleCount <= cycleCount + 1;

  //////////////////////////////////////////////////
  // reference model and checks
  //////////////////////////////////////////////////

  // 64-bit math, so the most negative / -1 case falls out by itself
  function automatic logic [xlen-1:0] refResult(input mduOpE op, input logic [xlen-1:0] a,
                                                input logic [xlen-1:0] b);
    longint      sa;
    longint      sb;
    longint      ua;
    longint      ub;
    logic [63:0] prod;
    sa = longint'($signed(a));
    sb = longint'($signed(b));
    ua = longint'({32'b0, a});
    ub = longint'({32'b0, b});
    case (op)
      opMul:    return 32'(sa * sb);
      opMulh:   prod = sa * sb;
      opMulhsu: prod = sa * ub;
      opMulhu:  prod = ua * ub;  // wraps, but the bits mod 2^64 are right
      opDiv:    return (b == '0) ? '1 : 32'(sa / sb);
      opDivu:   return (b == '0) ? '1 : 32'(ua / ub);
      opRem:    return (b == '0) ? a : 32'(sa % sb);
      default:  return (b == '0) ? a : 32'(ua % ub);
    endcase
    return prod[63:32];
  endfunction

  task automatic checkValue(input string what, input logic [63:0] expected,
                            input logic [63:0] actual);
    if (expected !== actual) begin
      valueErrors++;
      $display("[ERROR] %s %s: expected %0h, actual %0h", testName, what, expected, actual);
    end
  endtask

  // results compared in issue order, sampled after the falling-edge drive settles
  always @(negedge clk) begin
    expectT exp;
    #1;
    if (externalStall && writeTag.valid) begin
      otherErrors++;
      $display("%s: write enable raised during an external stall", testName);
    end
    if (rstN && writeTag.valid) begin
      if (expectQ.size() == 0) begin
        otherErrors++;
        $display("%s: unexpected result for x%0d with nothing outstanding", testName,
                 writeTag.rd);
      end else begin
        exp = expectQ.pop_front();
        checkValue("rd", 64'(exp.tag.rd), 64'(writeTag.rd));
        checkValue("op", 64'(exp.tag.op), 64'(writeTag.op));
        checkValue("data", 64'(exp.data), 64'(writeData));
        if (exp.checkLat) begin
          checkValue("latency", 64'(exp.presCycle + 2), 64'(cycleCount));
        end
      end
    end
  end

  //////////////////////////////////////////////////
  // issue helpers
  //////////////////////////////////////////////////

  // holds the op until a rising edge sees stallE low
  task automatic issueOp(input mduOpE op, input logic [xlen-1:0] a, input logic [xlen-1:0] b,
                         input logic checkLat);
    expectT      exp;
    logic        stalled;
    logic [31:0] presCycle;
    @(negedge clk);
    issueTag.valid = 1'b1;
    issueTag.op    = op;
    issueTag.rd    = regIdxT'($random(seed));
    srcA           = a;
    srcB           = b;
    presCycle      = cycleCount;
    lastStalls     = 0;
    do begin
      #1;
      stalled = stallE;
      @(posedge clk);
      if (stalled) begin
        lastStalls++;
        @(negedge clk);
      end
    end while (stalled);
    exp.tag       = issueTag;
    exp.data      = refResult(op, a, b);
    exp.presCycle = presCycle;
    exp.checkLat  = checkLat;
    expectQ.push_back(exp);
  endtask

  task automatic idleIssue();
    @(negedge clk);
    issueTag = '0;
  endtask

  task automatic waitDrain();
    int waited;
    waited = 0;
    while (expectQ.size() != 0 && waited < 2 * (xlen + 8)) begin
      @(negedge clk);
      waited++;
    end
    repeat (3) @(negedge clk);  // room for stray results
    if (expectQ.size() != 0) begin
      otherErrors++;
      $display("%s: %0d expected result(s) never arrived", testName, expectQ.size());
      expectQ.delete();
    end
  endtask

  //////////////////////////////////////////////////
  // tests
  //////////////////////////////////////////////////

  task automatic testMul();
    mduOpE           ops [4];
    logic [xlen-1:0] a;
    logic [xlen-1:0] b;
    ops = '{opMul, opMulh, opMulhsu, opMulhu};
    testName = "mul";
    for (int k = 0; k < 4; k++) begin
      for (int n = 0; n < mulPerOp; n++) begin
        a = (n < 4) ? mulCorners[n][63:32] : $random(seed);
        b = (n < 4) ? mulCorners[n][31:0] : $random(seed);
        issueOp(ops[k], a, b, 1'b1);
      end
    end
    idleIssue();
    waitDrain();
  endtask

  task automatic testDiv();
    mduOpE ops [4];
    ops = '{opDiv, opDivu, opRem, opRemu};
    testName = "div";
    for (int k = 0; k < 4; k++) begin
      for (int n = 0; n < divPerOp; n++) begin
        issueOp(ops[k], $random(seed), $random(seed), 1'b0);
      end
    end
    idleIssue();
    waitDrain();
  endtask

  task automatic testSpecial();
    logic [xlen-1:0] x;
    testName = "special";
    x = $random(seed);
    issueOp(opDiv, x, '0, 1'b0);
    issueOp(opDivu, x, '0, 1'b0);
    issueOp(opRem, x, '0, 1'b0);
    issueOp(opRemu, x, '0, 1'b0);
    issueOp(opDiv, 32'h8000_0000, '1, 1'b0);  // overflow
    issueOp(opRem, 32'h8000_0000, '1, 1'b0);
    idleIssue();
    waitDrain();
  endtask

  task automatic testBackToBack();
    testName = "backToBack";
    issueOp(opMul, $random(seed), $random(seed), 1'b1);
    issueOp(opMulhu, $random(seed), $random(seed), 1'b1);
    issueOp(opDiv, $random(seed), $random(seed), 1'b0);
    checkValue("divide stall cycles", 64'(xlen + 1), 64'(lastStalls));
    issueOp(opMulh, $random(seed), $random(seed), 1'b1);
    issueOp(opMulhsu, $random(seed), $random(seed), 1'b1);
    idleIssue();
    waitDrain();
  endtask

  task automatic testFlush();
    testName = "flush";
    @(negedge clk);
    issueTag.valid = 1'b1;
    issueTag.op    = opDiv;
    issueTag.rd    = regIdxT'($random(seed));
    srcA           = $random(seed);
    srcB           = $random(seed);
    repeat (5) @(negedge clk);
    flushE = 1'b1;  // kill the divide mid-iteration
    @(negedge clk);
    flushE   = 1'b0;
    issueTag = '0;
    issueOp(opMul, $random(seed), $random(seed), 1'b1);
    issueOp(opRemu, $random(seed), $random(seed), 1'b0);
    idleIssue();
    waitDrain();
  endtask

  task automatic testStall();
    testName = "externalStall";
    fork
      begin
        issueOp(opMul, $random(seed), $random(seed), 1'b0);
        issueOp(opMulh, $random(seed), $random(seed), 1'b0);
        issueOp(opDivu, $random(seed), $random(seed), 1'b0);
        issueOp(opMulhu, $random(seed), $random(seed), 1'b0);
        issueOp(opRem, $random(seed), $random(seed), 1'b0);
        issueOp(opMul, $random(seed), $random(seed), 1'b0);
      end
      begin
        repeat (3) @(negedge clk);
        externalStall = 1'b1;
        repeat (6) @(negedge clk);
        externalStall = 1'b0;
      end
    join
    idleIssue();
    waitDrain();
  endtask

  //////////////////////////////////////////////////
  // main sequence and watchdog
  //////////////////////////////////////////////////

  initial begin
    seed          = 32'hb5ee_7b52;
    issueTag      = '0;
    srcA          = '0;
    srcB          = '0;
    flushE        = 1'b0;
    externalStall = 1'b0;
    testName      = "reset";
    wait (rstN === 1'b1);
    @(negedge clk);
    #1;
    checkValue("stallE", 64'(0), 64'(stallE));
    checkValue("valid", 64'(0), 64'(writeTag.valid));
    testMul();
    testDiv();
    testSpecial();
    testBackToBack();
    testFlush();
    testStall();
    $display("Summary: %0d value mismatches, %0d other errors", valueErrors, otherErrors);
    if (valueErrors + otherErrors == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

  initial begin
    #(periodNs * (resetCycles + numOps * (xlen + 8)));
    $display("Watchdog: tests did not finish within the cycle budget");
    $display("Simulation FAILED");
    $finish;
  end

endmodule

//--- list.f
logic/mduPkg.sv
logic/hazardCtl.sv
logic/mulPipe.sv
logic/divFsm.sv
logic/divCounter.sv
logic/divDatapath.sv
logic/mduWriteback.sv
logic/mduTop.sv
sim/clkGen.sv
sim/mduTb.sv

//--- Makefile
# Verilator build and run of the MDU testbench

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --top-module mduTb -f list.f \
		-Mdir obj_dir -o mduSim

run: compile
	out="$$(./obj_dir/mduSim)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^Simulation PASSED$$"

clean:
	rm -rf obj_dir
